// ==== gpu.f ====
gpu_pkg.sv
gpu_pix_if.sv
gpu_apb_regs.sv
gpu_cmd_fifo.sv
gpu_draw_ctrl.sv
gpu_line_raster.sv
gpu_rect_fill.sv
gpu_pixel_out.sv
gpu.sv
tb_gpu_checker.sv
tb_gpu.sv

// ==== gpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [7:0]                 paddr_i,
  input  logic [31:0]                pwdata_i,
  output logic [31:0]                prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  output logic                       pix_we_o,
  output logic [gpu_pkg::GPU_AW-1:0] pix_addr_o,
  output logic [gpu_pkg::GPU_CW-1:0] pix_rgb_o,
  output logic                       buffer_select_o,
  output logic                       fifo_full_o
);

  gpu_pkg::gpu_cmd_t          cmd_data, cmd_head;
  logic                       cmd_push, cmd_pop, cmd_full, cmd_empty, busy;
  logic                       pix_valid, flip;
  logic [gpu_pkg::GPU_XW-1:0] pix_x;
  logic [gpu_pkg::GPU_YW-1:0] pix_y;
  logic [gpu_pkg::GPU_CW-1:0] pix_rgb;

  gpu_pix_if line_if ();
  gpu_pix_if rect_if ();

  // ##################################################
  // host side
  // ##################################################
  gpu_apb_regs u_regs (
    .clk(clk), .rst_i(rst_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .cmd_full_i(cmd_full), .cmd_empty_i(cmd_empty), .busy_i(busy),
    .cmd_push_o(cmd_push), .cmd_data_o(cmd_data)
  );

  gpu_cmd_fifo u_fifo (
    .clk(clk), .rst_i(rst_i),
    .push_i(cmd_push), .data_i(cmd_data), .pop_i(cmd_pop),
    .head_o(cmd_head), .empty_o(cmd_empty), .full_o(cmd_full)
  );

  // ##################################################
  // drawing side
  // ##################################################
  gpu_draw_ctrl u_ctrl (
    .clk(clk), .rst_i(rst_i),
    .head_i(cmd_head), .empty_i(cmd_empty),
    .pop_o(cmd_pop), .busy_o(busy),
    .line(line_if.ctrl), .rect(rect_if.ctrl),
    .pix_valid_o(pix_valid), .pix_x_o(pix_x), .pix_y_o(pix_y),
    .pix_rgb_o(pix_rgb), .flip_o(flip)
  );

  gpu_line_raster u_line (.clk(clk), .rst_i(rst_i), .pix(line_if.engine));
  gpu_rect_fill   u_rect (.clk(clk), .rst_i(rst_i), .pix(rect_if.engine));

  gpu_pixel_out u_pix (
    .clk(clk), .rst_i(rst_i),
    .valid_i(pix_valid), .x_i(pix_x), .y_i(pix_y), .rgb_i(pix_rgb), .flip_i(flip),
    .pix_we_o(pix_we_o), .pix_addr_o(pix_addr_o), .pix_rgb_o(pix_rgb_o),
    .buffer_select_o(buffer_select_o)
  );

  always_ff @(posedge clk) begin
    if (rst_i) fifo_full_o <= 1'b0;
    else       fifo_full_o <= cmd_full;  // registered full flag for the host
  end

endmodule

`default_nettype wire

// ==== gpu_apb_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_apb_regs (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [7:0]                  paddr_i,
  input  logic [31:0]                 pwdata_i,
  output logic [31:0]                 prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  input  logic                        cmd_full_i,
  input  logic                        cmd_empty_i,
  input  logic                        busy_i,
  output logic                        cmd_push_o,
  output gpu_pkg::gpu_cmd_t           cmd_data_o
);

  logic [gpu_pkg::GPU_XW-1:0] x0_q, x1_q;
  logic [gpu_pkg::GPU_YW-1:0] y0_q, y1_q;
  logic [gpu_pkg::GPU_CW-1:0] color_q;
  logic                       access, wr, mapped, is_cmd;
  gpu_pkg::gpu_op_e           wr_op;

  assign access   = psel_i && penable_i;  // no wait states
  assign wr       = access && pwrite_i;
  assign is_cmd   = (paddr_i == gpu_pkg::REG_CMD);
  assign wr_op    = gpu_pkg::gpu_op_e'(pwdata_i[1:0]);
  assign pready_o = 1'b1;

  // read mux and address decode
  always_comb begin
    mapped   = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      gpu_pkg::REG_P0: begin
        prdata_o[gpu_pkg::GPU_XW-1:0] = x0_q;
        prdata_o[8 +: gpu_pkg::GPU_YW] = y0_q;
      end
      gpu_pkg::REG_P1: begin
        prdata_o[gpu_pkg::GPU_XW-1:0] = x1_q;
        prdata_o[8 +: gpu_pkg::GPU_YW] = y1_q;
      end
      gpu_pkg::REG_COLOR:  prdata_o[gpu_pkg::GPU_CW-1:0] = color_q;
      gpu_pkg::REG_CMD:    prdata_o = '0;  // write only
      gpu_pkg::REG_STATUS: prdata_o[2:0] = {busy_i, cmd_full_i, cmd_empty_i};
      default:             mapped = 1'b0;
    endcase
  end

  // unmapped, cmd read, or cmd write into a full fifo
  assign pslverr_o = access && (!mapped || (is_cmd && (!pwrite_i || cmd_full_i)));

  assign cmd_push_o = wr && is_cmd && !cmd_full_i && (wr_op != gpu_pkg::OP_NOP);

  assign cmd_data_o.op    = wr_op;
  assign cmd_data_o.x0    = x0_q;
  assign cmd_data_o.y0    = y0_q;
  assign cmd_data_o.x1    = x1_q;
  assign cmd_data_o.y1    = y1_q;
  assign cmd_data_o.color = color_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      x0_q    <= '0;
      y0_q    <= '0;
      x1_q    <= '0;
      y1_q    <= '0;
      color_q <= '0;
    end else if (wr) begin
      case (paddr_i)
        gpu_pkg::REG_P0: begin
          x0_q <= pwdata_i[gpu_pkg::GPU_XW-1:0];
          y0_q <= pwdata_i[8 +: gpu_pkg::GPU_YW];
        end
        gpu_pkg::REG_P1: begin
          x1_q <= pwdata_i[gpu_pkg::GPU_XW-1:0];
          y1_q <= pwdata_i[8 +: gpu_pkg::GPU_YW];
        end
        gpu_pkg::REG_COLOR: color_q <= pwdata_i[gpu_pkg::GPU_CW-1:0];
        default: ;
      endcase
    end
  end

  // an accepted command is held by the fifo on the next cycle
  a_push_lands: assert property (@(posedge clk) disable iff (rst_i)
    cmd_push_o |=> !cmd_empty_i)
    else $error("pushed command missing from the fifo");

endmodule

`default_nettype wire

// ==== gpu_cmd_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_cmd_fifo (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              push_i,
  input  gpu_pkg::gpu_cmd_t data_i,
  input  logic              pop_i,
  output gpu_pkg::gpu_cmd_t head_o,
  output logic              empty_o,
  output logic              full_o
);

  gpu_pkg::gpu_cmd_t mem [gpu_pkg::GPU_FIFO_DEPTH];

  logic [$clog2(gpu_pkg::GPU_FIFO_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;  // wrap naturally
  logic [$clog2(gpu_pkg::GPU_FIFO_DEPTH):0]   count_q;
  logic                                       do_push, do_pop;

  assign empty_o = (count_q == 0);
  assign full_o  = (count_q == gpu_pkg::GPU_FIFO_DEPTH);
  assign head_o  = mem[rd_ptr_q];  // head visible before the pop edge

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop)      count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
    !(pop_i && empty_o))
    else $error("pop from an empty command fifo");

endmodule

`default_nettype wire

// ==== gpu_draw_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_draw_ctrl (
  input  logic                       clk,
  input  logic                       rst_i,
  input  gpu_pkg::gpu_cmd_t          head_i,
  input  logic                       empty_i,
  output logic                       pop_o,
  output logic                       busy_o,
  gpu_pix_if.ctrl                    line,
  gpu_pix_if.ctrl                    rect,
  output logic                       pix_valid_o,
  output logic [gpu_pkg::GPU_XW-1:0] pix_x_o,
  output logic [gpu_pkg::GPU_YW-1:0] pix_y_o,
  output logic [gpu_pkg::GPU_CW-1:0] pix_rgb_o,
  output logic                       flip_o
);

  typedef enum logic [2:0] {IDLE, POP, RUN_LINE, RUN_RECT, FLIP} state_e;

  state_e            state_q, state_d;
  gpu_pkg::gpu_cmd_t cmd_q;

  assign pop_o  = (state_q == IDLE) && !empty_i;
  assign busy_o = (state_q != IDLE);
  assign flip_o = (state_q == FLIP);  // toggles the buffer on the next edge

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (!empty_i) state_d = (head_i.op == gpu_pkg::OP_FLUSH) ? FLIP : POP;
      POP: begin
        case (cmd_q.op)
          gpu_pkg::OP_LINE: state_d = RUN_LINE;
          gpu_pkg::OP_RECT: state_d = RUN_RECT;
          default:          state_d = IDLE;
        endcase
      end
      RUN_LINE: if (line.done) state_d = IDLE;
      RUN_RECT: if (rect.done) state_d = IDLE;
      default:  state_d = IDLE;  // FLIP lasts one cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) state_q <= IDLE;
    else       state_q <= state_d;
  end

  always_ff @(posedge clk) begin
    if (pop_o) cmd_q <= head_i;
  end

  // ##################################################
  // engine kick-off and pixel merge
  // ##################################################
  assign line.start = (state_q == POP) && (cmd_q.op == gpu_pkg::OP_LINE);
  assign rect.start = (state_q == POP) && (cmd_q.op == gpu_pkg::OP_RECT);
  assign line.p0    = {cmd_q.y0, cmd_q.x0};
  assign line.p1    = {cmd_q.y1, cmd_q.x1};
  assign rect.p0    = {cmd_q.y0, cmd_q.x0};
  assign rect.p1    = {cmd_q.y1, cmd_q.x1};

  assign pix_valid_o = line.valid || rect.valid;
  assign pix_x_o     = line.valid ? line.x : rect.x;
  assign pix_y_o     = line.valid ? line.y : rect.y;
  assign pix_rgb_o   = cmd_q.color;  // held for the whole command

  a_one_engine: assert property (@(posedge clk) disable iff (rst_i)
    !(line.valid && rect.valid))
    else $error("line and rect engines emitting together");

endmodule

`default_nettype wire

// ==== gpu_line_raster.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_line_raster (
  input  logic       clk,
  input  logic       rst_i,
  gpu_pix_if.engine  pix
);

  logic [gpu_pkg::GPU_XW-1:0] x_q, x_end_q, px0, px1;
  logic [gpu_pkg::GPU_YW-1:0] y_q, y_end_q, py0, py1;
  logic signed [gpu_pkg::GPU_EW-1:0] dx_q, dy_q, err_q;  // dy_q holds -|dy|
  logic signed [gpu_pkg::GPU_EW-1:0] ddx, ddy, adx, ady, e2, err_nxt;
  logic x_neg_q, y_neg_q, active_q;
  logic step_x, step_y, last;

  assign px0 = pix.p0[gpu_pkg::GPU_XW-1:0];
  assign py0 = pix.p0[gpu_pkg::GPU_XW +: gpu_pkg::GPU_YW];
  assign px1 = pix.p1[gpu_pkg::GPU_XW-1:0];
  assign py1 = pix.p1[gpu_pkg::GPU_XW +: gpu_pkg::GPU_YW];

  // signed deltas at start
  assign ddx = $signed({{(gpu_pkg::GPU_EW-gpu_pkg::GPU_XW){1'b0}}, px1})
             - $signed({{(gpu_pkg::GPU_EW-gpu_pkg::GPU_XW){1'b0}}, px0});
  assign ddy = $signed({{(gpu_pkg::GPU_EW-gpu_pkg::GPU_YW){1'b0}}, py1})
             - $signed({{(gpu_pkg::GPU_EW-gpu_pkg::GPU_YW){1'b0}}, py0});
  assign adx = (ddx < 0) ? -ddx : ddx;
  assign ady = (ddy < 0) ? -ddy : ddy;

  // both tests use the error before update
  assign e2      = err_q <<< 1;
  assign step_x  = (e2 >= dy_q);
  assign step_y  = (e2 <= dx_q);
  assign err_nxt = err_q + (step_x ? dy_q : '0) + (step_y ? dx_q : '0);
  assign last    = (x_q == x_end_q) && (y_q == y_end_q);

  always_ff @(posedge clk) begin
    if (rst_i)                 active_q <= 1'b0;
    else if (pix.start)        active_q <= 1'b1;
    else if (active_q && last) active_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (pix.start) begin
      x_q     <= px0;
      y_q     <= py0;
      x_end_q <= px1;
      y_end_q <= py1;
      dx_q    <= adx;
      dy_q    <= -ady;
      err_q   <= adx - ady;
      x_neg_q <= (ddx < 0);
      y_neg_q <= (ddy < 0);
    end else if (active_q && !last) begin
      if (step_x) x_q <= x_neg_q ? x_q - 1'b1 : x_q + 1'b1;
      if (step_y) y_q <= y_neg_q ? y_q - 1'b1 : y_q + 1'b1;
      err_q <= err_nxt;
    end
  end

  assign pix.valid = active_q;
  assign pix.x     = x_q;
  assign pix.y     = y_q;
  assign pix.done  = active_q && last;  // pixel equal to p1

endmodule

`default_nettype wire

// ==== gpu_pix_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// start and corner points go down to an engine, pixels come back up
interface gpu_pix_if;
  logic                                        start;
  logic [gpu_pkg::GPU_YW+gpu_pkg::GPU_XW-1:0]  p0;    // {y, x}
  logic [gpu_pkg::GPU_YW+gpu_pkg::GPU_XW-1:0]  p1;    // {y, x}
  logic                                        valid;
  logic [gpu_pkg::GPU_XW-1:0]                  x;
  logic [gpu_pkg::GPU_YW-1:0]                  y;
  logic                                        done;  // high with the last pixel

  modport engine (input start, p0, p1, output valid, x, y, done);
  modport ctrl   (output start, p0, p1, input valid, x, y, done);
endinterface

`default_nettype wire

// ==== gpu_pixel_out.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_pixel_out (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [gpu_pkg::GPU_XW-1:0] x_i,
  input  logic [gpu_pkg::GPU_YW-1:0] y_i,
  input  logic [gpu_pkg::GPU_CW-1:0] rgb_i,
  input  logic                       flip_i,
  output logic                       pix_we_o,
  output logic [gpu_pkg::GPU_AW-1:0] pix_addr_o,
  output logic [gpu_pkg::GPU_CW-1:0] pix_rgb_o,
  output logic                       buffer_select_o
);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pix_we_o        <= 1'b0;
      buffer_select_o <= 1'b0;
    end else begin
      pix_we_o <= valid_i;  // one cycle behind the engine
      if (flip_i) buffer_select_o <= ~buffer_select_o;
    end
  end

  always_ff @(posedge clk) begin
    pix_addr_o <= {y_i, x_i};  // row then column
    pix_rgb_o  <= rgb_i;
  end

  a_on_canvas: assert property (@(posedge clk) disable iff (rst_i)
    valid_i |-> (x_i < gpu_pkg::GPU_W) && (y_i < gpu_pkg::GPU_H))
    else $error("pixel outside the canvas");

endmodule

`default_nettype wire

// ==== gpu_pkg.sv ====
`default_nettype none

package gpu_pkg;

  // ##################################################
  // canvas and datapath sizes
  // ##################################################
  localparam int GPU_W          = 64;
  localparam int GPU_H          = 48;
  localparam int GPU_XW         = 6;
  localparam int GPU_YW         = 6;
  localparam int GPU_AW         = GPU_YW + GPU_XW; // row bits above column bits
  localparam int GPU_CW         = 24;
  localparam int GPU_FIFO_DEPTH = 4;
  localparam int GPU_EW         = GPU_XW + 4;     // signed bresenham error term

  // ##################################################
  // apb register map
  // ##################################################
  localparam logic [7:0] REG_P0     = 8'h00;
  localparam logic [7:0] REG_P1     = 8'h04;
  localparam logic [7:0] REG_COLOR  = 8'h08;
  localparam logic [7:0] REG_CMD    = 8'h0C;
  localparam logic [7:0] REG_STATUS = 8'h10;

  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_LINE  = 2'd1,
    OP_RECT  = 2'd2,
    OP_FLUSH = 2'd3
  } gpu_op_e;

  typedef struct packed {
    gpu_op_e                 op;
    logic [GPU_XW-1:0]       x0;
    logic [GPU_YW-1:0]       y0;
    logic [GPU_XW-1:0]       x1;
    logic [GPU_YW-1:0]       y1;
    logic [GPU_CW-1:0]       color;
  } gpu_cmd_t;

endpackage

`default_nettype wire

// ==== gpu_rect_fill.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_rect_fill (
  input  logic       clk,
  input  logic       rst_i,
  gpu_pix_if.engine  pix
);

  logic [gpu_pkg::GPU_XW-1:0] x_q, x_min_q, x_max_q, px0, px1;
  logic [gpu_pkg::GPU_YW-1:0] y_q, y_min_q, y_max_q, py0, py1;
  logic                       active_q, last_col, last;

  assign px0 = pix.p0[gpu_pkg::GPU_XW-1:0];
  assign py0 = pix.p0[gpu_pkg::GPU_XW +: gpu_pkg::GPU_YW];
  assign px1 = pix.p1[gpu_pkg::GPU_XW-1:0];
  assign py1 = pix.p1[gpu_pkg::GPU_XW +: gpu_pkg::GPU_YW];

  assign last_col = (x_q == x_max_q);
  assign last     = last_col && (y_q == y_max_q);

  always_ff @(posedge clk) begin
    if (rst_i)                 active_q <= 1'b0;
    else if (pix.start)        active_q <= 1'b1;
    else if (active_q && last) active_q <= 1'b0;
  end

  // row-major walk from the min corner
  always_ff @(posedge clk) begin
    if (pix.start) begin
      x_min_q <= (px0 < px1) ? px0 : px1;
      x_max_q <= (px0 < px1) ? px1 : px0;
      y_min_q <= (py0 < py1) ? py0 : py1;
      y_max_q <= (py0 < py1) ? py1 : py0;
      x_q     <= (px0 < px1) ? px0 : px1;
      y_q     <= (py0 < py1) ? py0 : py1;
    end else if (active_q && !last) begin
      if (last_col) begin
        x_q <= x_min_q;  // next row
        y_q <= y_q + 1'b1;
      end else begin
        x_q <= x_q + 1'b1;
      end
    end
  end

  assign pix.valid = active_q;
  assign pix.x     = x_q;
  assign pix.y     = y_q;
  assign pix.done  = active_q && last;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the gpu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gpu -Mdir obj_dir -f gpu.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/Vtb_gpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// ==== tb_gpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_gpu;

  typedef struct packed {
    logic [7:0]  addr;
    logic        wr;
    logic [31:0] data;
    logic [31:0] mask;  // read compare mask
    logic [31:0] exp;
    logic        err;
  } apb_op_t;

  logic        clk;
  logic        rst_i;
  logic        psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr, pix_we, bsel, fifo_full;
  logic [11:0] pix_addr;
  logic [23:0] pix_rgb;
  logic [31:0] exp_data, exp_mask;
  logic        exp_err;
  int          err_cnt, pend;

  apb_op_t     ops[$];
  string       test_name[$];
  int          test_first[$];
  logic [16:0] lfsr_q;

  gpu uut (
    .clk(clk), .rst_i(rst_i),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata),
    .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .pix_we_o(pix_we), .pix_addr_o(pix_addr), .pix_rgb_o(pix_rgb),
    .buffer_select_o(bsel), .fifo_full_o(fifo_full)
  );

  tb_gpu_checker chk (
    .clk(clk), .rst_i(rst_i),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_i(prdata),
    .pready_i(pready), .pslverr_i(pslverr),
    .pix_we_i(pix_we), .pix_addr_i(pix_addr), .pix_rgb_i(pix_rgb),
    .buffer_select_i(bsel), .fifo_full_i(fifo_full),
    .exp_data_i(exp_data), .exp_mask_i(exp_mask), .exp_err_i(exp_err),
    .err_cnt_o(err_cnt), .pend_o(pend)
  );

  always #2 clk = ~clk;  // 4 ns period

  // fibonacci lfsr with taps x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    lfsr_next = {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // ##################################################
  // stimulus table
  // ##################################################
  task automatic start_test(input string name);
    test_name.push_back(name);
    test_first.push_back(ops.size());
  endtask

  task automatic add_write(input logic [7:0] a, input logic [31:0] d, input logic err);
    ops.push_back({a, 1'b1, d, 32'h0, 32'h0, err});
  endtask

  task automatic add_read(input logic [7:0] a, input logic [31:0] mask,
                          input logic [31:0] exp, input logic err);
    ops.push_back({a, 1'b0, 32'h0, mask, exp, err});
  endtask

  task automatic add_points(input logic [5:0] x0, input logic [5:0] y0,
                            input logic [5:0] x1, input logic [5:0] y1);
    add_write(gpu_pkg::REG_P0, {18'h0, y0, 2'b00, x0}, 1'b0);
    add_write(gpu_pkg::REG_P1, {18'h0, y1, 2'b00, x1}, 1'b0);
  endtask

  task automatic add_draw(input gpu_pkg::gpu_op_e op, input logic [5:0] x0,
                          input logic [5:0] y0, input logic [5:0] x1,
                          input logic [5:0] y1, input logic [23:0] rgb);
    add_points(x0, y0, x1, y1);
    add_write(gpu_pkg::REG_COLOR, {8'h0, rgb}, 1'b0);
    add_write(gpu_pkg::REG_CMD, {30'h0, op}, 1'b0);
  endtask

  task automatic build_table();
    logic [31:0] v;
    logic [5:0]  rx0, ry0, rx1, ry1;
    start_test("reset_and_regs");
    add_read(gpu_pkg::REG_STATUS, 32'hFFFF_FFFF, 32'h1, 1'b0);  // empty, idle
    add_write(gpu_pkg::REG_P0, 32'h0000_2A15, 1'b0);
    add_read(gpu_pkg::REG_P0, 32'hFFFF_FFFF, 32'h0000_2A15, 1'b0);
    add_write(gpu_pkg::REG_P1, 32'hFFFF_FFFF, 1'b0);
    add_read(gpu_pkg::REG_P1, 32'hFFFF_FFFF, 32'h0000_3F3F, 1'b0);
    add_write(gpu_pkg::REG_COLOR, 32'hAB12_3456, 1'b0);
    add_read(gpu_pkg::REG_COLOR, 32'hFFFF_FFFF, 32'h0012_3456, 1'b0);
    add_read(8'h20, 32'h0, 32'h0, 1'b1);              // unmapped
    add_write(8'h14, 32'h1, 1'b1);
    add_read(gpu_pkg::REG_CMD, 32'h0, 32'h0, 1'b1);   // write only
    add_write(gpu_pkg::REG_CMD, 32'h0, 1'b0);         // nop, nothing queued

    start_test("lines_axis");
    add_draw(gpu_pkg::OP_LINE, 5, 5, 20, 5, 24'h1111_11);
    add_draw(gpu_pkg::OP_LINE, 20, 9, 5, 9, 24'h2222_22);
    add_draw(gpu_pkg::OP_LINE, 10, 2, 10, 12, 24'h3333_33);
    add_draw(gpu_pkg::OP_LINE, 12, 12, 12, 2, 24'h4444_44);
    add_draw(gpu_pkg::OP_LINE, 7, 7, 7, 7, 24'h5555_55);  // single point

    start_test("lines_octants");
    add_draw(gpu_pkg::OP_LINE, 32, 24, 40, 27, 24'hA00001);
    add_draw(gpu_pkg::OP_LINE, 32, 24, 35, 33, 24'hA00002);
    add_draw(gpu_pkg::OP_LINE, 32, 24, 29, 33, 24'hA00003);
    add_draw(gpu_pkg::OP_LINE, 32, 24, 24, 27, 24'hA00004);
    add_draw(gpu_pkg::OP_LINE, 32, 24, 24, 21, 24'hA00005);
    add_draw(gpu_pkg::OP_LINE, 32, 24, 29, 15, 24'hA00006);
    add_draw(gpu_pkg::OP_LINE, 32, 24, 35, 15, 24'hA00007);
    add_draw(gpu_pkg::OP_LINE, 32, 24, 40, 21, 24'hA00008);

    start_test("lines_random");
    repeat (8) begin
      take_bits(6, v);
      rx0 = v[5:0];
      take_bits(6, v);
      ry0 = 6'(v % 48);  // keep rows on the canvas
      take_bits(6, v);
      rx1 = v[5:0];
      take_bits(6, v);
      ry1 = 6'(v % 48);
      take_bits(24, v);
      add_draw(gpu_pkg::OP_LINE, rx0, ry0, rx1, ry1, v[23:0]);
    end

    start_test("rects");
    add_draw(gpu_pkg::OP_RECT, 20, 10, 15, 6, 24'hB00001);   // swapped corners
    add_draw(gpu_pkg::OP_RECT, 3, 10, 3, 4, 24'hB00002);     // one column
    add_draw(gpu_pkg::OP_RECT, 18, 40, 10, 40, 24'hB00003);  // one row
    add_draw(gpu_pkg::OP_RECT, 0, 0, 0, 0, 24'hB00004);
    add_draw(gpu_pkg::OP_RECT, 63, 47, 60, 44, 24'hB00005);

    start_test("flush");
    add_draw(gpu_pkg::OP_LINE, 1, 1, 6, 3, 24'hC00001);
    add_write(gpu_pkg::REG_CMD, {30'h0, gpu_pkg::OP_FLUSH}, 1'b0);
    add_draw(gpu_pkg::OP_RECT, 2, 2, 3, 3, 24'hC00002);
    add_write(gpu_pkg::REG_CMD, {30'h0, gpu_pkg::OP_FLUSH}, 1'b0);

    start_test("overflow");
    add_draw(gpu_pkg::OP_LINE, 0, 0, 63, 47, 24'hD00001);  // 64 pixels keep the engine busy
    add_points(2, 2, 4, 3);
    add_write(gpu_pkg::REG_CMD, {30'h0, gpu_pkg::OP_RECT}, 1'b0);
    add_write(gpu_pkg::REG_CMD, {30'h0, gpu_pkg::OP_LINE}, 1'b0);
    add_write(gpu_pkg::REG_CMD, {30'h0, gpu_pkg::OP_FLUSH}, 1'b0);
    add_write(gpu_pkg::REG_CMD, {30'h0, gpu_pkg::OP_RECT}, 1'b0);
    add_write(gpu_pkg::REG_CMD, {30'h0, gpu_pkg::OP_LINE}, 1'b1);  // fifo full
    add_read(gpu_pkg::REG_STATUS, 32'h7, 32'h6, 1'b0);             // busy and full
  endtask

  // setup, access, then one idle cycle
  task automatic apb_xfer(input apb_op_t op, output logic [31:0] rdata);
    @(negedge clk);
    psel     = 1'b1;
    penable  = 1'b0;
    pwrite   = op.wr;
    paddr    = op.addr;
    pwdata   = op.data;
    exp_data = op.exp;
    exp_mask = op.mask;
    exp_err  = op.err;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_idle(output logic hung);
    logic [31:0] st;
    int          polls;
    hung = 1'b1;
    for (polls = 0; polls < 400; polls++) begin
      apb_xfer({gpu_pkg::REG_STATUS, 1'b0, 32'h0, 32'h0, 32'h0, 1'b0}, st);
      if (st[2:0] == 3'b001) begin  // empty and not busy
        hung = 1'b0;
        break;
      end
    end
  endtask

  initial begin
    int          t, i, last, w, errs_before, fails;
    logic        hung, lost;
    logic [31:0] rdata;
    clk      = 1'b0;
    rst_i    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    exp_data = '0;
    exp_mask = '0;
    exp_err  = 1'b0;
    lfsr_q   = 17'd72565;
    fails    = 0;
    hung     = 1'b0;
    build_table();
    repeat (8) @(negedge clk);
    rst_i = 1'b0;

    for (t = 0; t < test_name.size() && !hung; t++) begin
      errs_before = err_cnt;
      lost        = 1'b0;
      last        = (t + 1 < test_name.size()) ? test_first[t+1] : ops.size();
      for (i = test_first[t]; i < last; i++) begin
        apb_xfer(ops[i], rdata);
      end
      wait_idle(hung);
      if (hung) begin
        $display("timeout: the DUT stayed busy through 400 status polls in test %s",
                 test_name[t]);
        lost = 1'b1;
      end else begin
        for (w = 0; w < 16 && pend != 0; w++) begin
          @(negedge clk);
        end
        if (pend != 0) begin
          $display("test %s: %0d expected pixels or flips never arrived", test_name[t], pend);
          lost = 1'b1;
        end
      end
      if (lost || err_cnt != errs_before) begin
        fails++;
        $display("test %-16s fail, %0d errors", test_name[t], err_cnt - errs_before);
      end else begin
        $display("test %-16s ok", test_name[t]);
      end
    end

    $display("tests %0d, failed %0d, checker errors %0d", t, fails, err_cnt);
    if (fails == 0 && err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_gpu_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_gpu_checker (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  input  logic [31:0] prdata_i,
  input  logic        pready_i,
  input  logic        pslverr_i,
  input  logic        pix_we_i,
  input  logic [11:0] pix_addr_i,
  input  logic [23:0] pix_rgb_i,
  input  logic        buffer_select_i,
  input  logic        fifo_full_i,
  input  logic [31:0] exp_data_i,   // expected read data for the current access
  input  logic [31:0] exp_mask_i,   // zero means the read data is not compared
  input  logic        exp_err_i,
  output int          err_cnt_o,
  output int          pend_o
);

  typedef struct packed {
    logic        flip;  // buffer flip marker instead of a pixel
    logic [11:0] addr;
    logic [23:0] rgb;
  } exp_t;

  exp_t        exp_q[$];
  exp_t        got;
  logic [5:0]  x0, y0, x1, y1;  // shadow of the point registers
  logic [23:0] color;
  logic        bsel_exp;
  int          errs = 0;

  task automatic report_error(input string msg);
    $display("** Error @ %0t ns: %s", $time, msg);
    errs++;
  endtask

  task automatic push_pix(input int x, input int y, input logic [23:0] rgb);
    exp_q.push_back({1'b0, 6'(y), 6'(x), rgb});  // row bits above column bits
  endtask

  // ##################################################
  // reference models of the two engines
  // ##################################################
  task automatic add_line(input int ax, input int ay, input int bx, input int by,
                          input logic [23:0] rgb);
    int dx, dy, sx, sy, err, e2, x, y, n;
    dx  = (bx > ax) ? bx - ax : ax - bx;
    dy  = (by > ay) ? ay - by : by - ay;  // negative magnitude
    sx  = (bx < ax) ? -1 : 1;
    sy  = (by < ay) ? -1 : 1;
    err = dx + dy;
    x   = ax;
    y   = ay;
    n   = 0;
    push_pix(x, y, rgb);
    while (!(x == bx && y == by) && n < 256) begin
      e2 = 2 * err;  // both steps test the old error
      if (e2 >= dy) begin
        err = err + dy;
        x   = x + sx;
      end
      if (e2 <= dx) begin
        err = err + dx;
        y   = y + sy;
      end
      push_pix(x, y, rgb);
      n++;
    end
  endtask

  task automatic add_rect(input int ax, input int ay, input int bx, input int by,
                          input logic [23:0] rgb);
    int xl, xh, yl, yh, x, y;
    xl = (ax < bx) ? ax : bx;
    xh = (ax < bx) ? bx : ax;
    yl = (ay < by) ? ay : by;
    yh = (ay < by) ? by : ay;
    for (y = yl; y <= yh; y++) begin
      for (x = xl; x <= xh; x++) begin
        push_pix(x, y, rgb);
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_i) begin
      exp_q.delete();
      bsel_exp = 1'b0;
      x0       = '0;
      y0       = '0;
      x1       = '0;
      y1       = '0;
      color    = '0;
    end else begin
      if (psel_i && penable_i) begin  // access phase completes here
        if (pready_i !== 1'b1)
          report_error($sformatf("pready %b at addr %h, expected 1", pready_i, paddr_i));
        if (pslverr_i !== exp_err_i)
          report_error($sformatf("pslverr %b at addr %h, expected %b",
                                 pslverr_i, paddr_i, exp_err_i));
        if (!pwrite_i && ((prdata_i ^ exp_data_i) & exp_mask_i) !== '0)
          report_error($sformatf("read %h from addr %h, expected %h (mask %h)",
                                 prdata_i, paddr_i, exp_data_i, exp_mask_i));
        if (!pwrite_i && paddr_i == gpu_pkg::REG_STATUS && exp_mask_i[1] &&
            fifo_full_i !== exp_data_i[1])
          report_error($sformatf("fifo_full_o %b, expected %b", fifo_full_i, exp_data_i[1]));
        if (pwrite_i) begin
          case (paddr_i)
            gpu_pkg::REG_P0: begin
              x0 = pwdata_i[5:0];
              y0 = pwdata_i[13:8];
            end
            gpu_pkg::REG_P1: begin
              x1 = pwdata_i[5:0];
              y1 = pwdata_i[13:8];
            end
            gpu_pkg::REG_COLOR: color = pwdata_i[23:0];
            gpu_pkg::REG_CMD: begin
              if (!exp_err_i) begin  // refused commands draw nothing
                case (pwdata_i[1:0])
                  gpu_pkg::OP_LINE:  add_line(x0, y0, x1, y1, color);
                  gpu_pkg::OP_RECT:  add_rect(x0, y0, x1, y1, color);
                  gpu_pkg::OP_FLUSH: exp_q.push_back({1'b1, 12'h0, 24'h0});
                  default: ;
                endcase
              end
            end
            default: ;
          endcase
        end
      end

      // ##################################################
      // pixel port and buffer select
      // ##################################################
      if (pix_we_i !== 1'b0) begin
        if (exp_q.size() == 0) begin
          report_error($sformatf("unexpected pixel write at %h", pix_addr_i));
        end else if (exp_q[0].flip) begin
          report_error($sformatf("pixel write at %h before the expected buffer flip",
                                 pix_addr_i));
        end else begin
          got = exp_q.pop_front();
          if (pix_addr_i !== got.addr || pix_rgb_i !== got.rgb)
            report_error($sformatf("pixel %h rgb %h, expected %h rgb %h",
                                   pix_addr_i, pix_rgb_i, got.addr, got.rgb));
        end
      end
      if (buffer_select_i !== bsel_exp) begin
        if (exp_q.size() == 0 || !exp_q[0].flip)
          report_error("buffer select toggled with no flush due");
        else
          got = exp_q.pop_front();
        bsel_exp = buffer_select_i;
      end
    end
    err_cnt_o = errs;
    pend_o    = exp_q.size();
  end

endmodule

`default_nettype wire
